// ==== flist.f ====
src/echo_mem_pkg.sv
src/echo_mix_pkg.sv
src/ram_port_if.sv
src/echo_tap_if.sv
src/echo_scheduler.sv
src/history_ram.sv
src/echo_mixer.sv
src/echo_unit_top.sv
tests/tb_clock_gen.sv
tests/echo_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the echo unit testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module echo_unit_tb -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vecho_unit_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

// ==== tests/echo_cases.txt ====
# S <sample hex> <tap delay> <short shift> <long shift> drives one sample
# B <count> <tap delay> <short shift> <long shift> drives count random samples
S 1234 0 0 0
S fedc 3 1 1
S 7000 1 0 0
S 7000 1 0 0
S 9000 1 0 0
S 9000 1 0 0
B 40 1 1 2
B 40 5 0 1
B 60 200 2 3
B 80 17 3 0
B 64 0 1 0
B 50 0 0 0
S 0100 2 3 3
S 8000 255 0 0
S 7fff 1 0 0
B 30 128 2 2
S 4000 0 0 0

// ==== tests/echo_unit_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Runs tests/echo_cases.txt through the echo unit and checks every output
// Shifts are held one cycle after each line because the mixer samples them late
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_unit_tb;

  localparam int SEED = 64;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_MARGIN = 50;
  localparam int MAX_CMDS = 64;

  logic                  clk;
  logic                  reset;
  echo_mem_pkg::sample_t sample_in;
  logic                  sample_valid;
  echo_mem_pkg::addr_t   tap_delay;
  echo_mix_pkg::shift_t  short_shift;
  echo_mix_pkg::shift_t  long_shift;
  logic                  ready;
  echo_mem_pkg::sample_t echo_out;
  logic                  echo_valid;

  // Commands from the case file, kind is S or B
  byte cmd_kind  [MAX_CMDS];
  int  cmd_value [MAX_CMDS];
  int  cmd_delay [MAX_CMDS];
  int  cmd_short [MAX_CMDS];
  int  cmd_long  [MAX_CMDS];
  int  cmd_count = 0;
  int  total_samples = 0;

  // Reference history, starts at zero like the cleared memory
  echo_mem_pkg::sample_t hist [echo_mem_pkg::MEM_DEPTH];
  int                    model_wptr = 0;
  echo_mem_pkg::sample_t expected_q [$];
  // Bit 1 marks an accept from two cycles back, which is due at the output now
  logic [1:0]            valid_pipe = '0;
  logic                  run_phase = 1'b0;

  int error_count = 0;
  int checked_count = 0;
  int cycle_count = 0;
  int timeout_limit = 0;

  tb_clock_gen u_clock (.clk(clk));

  echo_unit_top dut (
    .clk          (clk),
    .reset        (reset),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .tap_delay    (tap_delay),
    .short_shift  (short_shift),
    .long_shift   (long_shift),
    .ready        (ready),
    .echo_out     (echo_out),
    .echo_valid   (echo_valid)
  );

  // Dry sample plus both echoes, each shifted right with its sign kept, then clipped
  function automatic echo_mem_pkg::sample_t mix_expected(
    input echo_mem_pkg::sample_t dry,
    input echo_mem_pkg::sample_t short_echo,
    input echo_mem_pkg::sample_t long_echo,
    input echo_mix_pkg::shift_t  ss,
    input echo_mix_pkg::shift_t  ls
  );
    int sum;
    sum = int'(dry) + (int'(short_echo) >>> ss) + (int'(long_echo) >>> ls);
    if (sum > int'(echo_mix_pkg::SAT_MAX)) begin
      sum = int'(echo_mix_pkg::SAT_MAX);
    end else if (sum < int'(echo_mix_pkg::SAT_MIN)) begin
      sum = int'(echo_mix_pkg::SAT_MIN);
    end
    return echo_mem_pkg::sample_t'(sum);
  endfunction

  task automatic read_cases();
    int    fd;
    int    fields;
    int    v0;
    int    v1;
    int    v2;
    int    v3;
    byte   kind;
    string line;
    fd = $fopen("tests/echo_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/echo_cases.txt");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1) begin
          kind = line.getc(0);
          // Sample values are hex, burst counts are decimal
          if (kind == "S") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %d %d %d", v0, v1, v2, v3);
          end else if (kind == "B") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", v0, v1, v2, v3);
          end else if (kind == "#") begin
            fields = -1;
          end else begin
            fields = 0;
          end
          if (fields == 4 && cmd_count < MAX_CMDS) begin
            cmd_kind[cmd_count]  = kind;
            cmd_value[cmd_count] = v0;
            cmd_delay[cmd_count] = v1;
            cmd_short[cmd_count] = v2;
            cmd_long[cmd_count]  = v3;
            cmd_count++;
            total_samples += (kind == "S") ? 1 : v0;
          end else if (fields >= 0) begin
            $display("Case file line could not be used: %s", line);
            error_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Runs right after a falling edge, where all DUT outputs are settled
  task automatic check_outputs();
    echo_mem_pkg::sample_t expected;
    if (echo_valid !== valid_pipe[1]) begin
      $display("CHECK FAILED at %0t: echo_valid expected %0b, got %0b",
               $time, valid_pipe[1], echo_valid);
      error_count++;
    end
    if (echo_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("Error at %0t: echo_valid came with no sample in flight", $time);
        error_count++;
      end else begin
        expected = expected_q.pop_front();
        checked_count++;
        if (echo_out !== expected) begin
          $display("CHECK FAILED at %0t: echo_out expected %0d, got %0d",
                   $time, expected, echo_out);
          error_count++;
        end
      end
    end
  endtask

  // Ready only moves on a rising edge, so its value now decides the accept
  task automatic drive_cycle(
    input logic                  valid,
    input echo_mem_pkg::sample_t sample,
    input echo_mem_pkg::addr_t   delay,
    input echo_mix_pkg::shift_t  ss,
    input echo_mix_pkg::shift_t  ls
  );
    logic accept;
    int   short_idx;
    accept = valid && (ready === 1'b1);
    if (valid && run_phase && ready !== 1'b1) begin
      $display("CHECK FAILED at %0t: ready expected 1 after the clear phase, got %0b",
               $time, ready);
      error_count++;
    end
    sample_valid = valid;
    sample_in    = sample;
    tap_delay    = delay;
    short_shift  = ss;
    long_shift   = ls;
    if (accept) begin
      short_idx = (model_wptr - int'(delay)) & (echo_mem_pkg::MEM_DEPTH - 1);
      // Both reads see the history before this sample is stored
      expected_q.push_back(mix_expected(sample, hist[short_idx], hist[model_wptr], ss, ls));
      hist[model_wptr] = sample;
      model_wptr = (model_wptr + 1) % echo_mem_pkg::MEM_DEPTH;
    end
    valid_pipe = {valid_pipe[0], accept};
  endtask

  task automatic run_cycle(
    input logic                  valid,
    input echo_mem_pkg::sample_t sample,
    input echo_mem_pkg::addr_t   delay,
    input echo_mix_pkg::shift_t  ss,
    input echo_mix_pkg::shift_t  ls
  );
    @(negedge clk);
    check_outputs();
    drive_cycle(valid, sample, delay, ss, ls);
  endtask

  // Strobes every cycle while ready is low and counts those cycles
  task automatic watch_clear_phase();
    int   low_cycles;
    logic done;
    low_cycles = 0;
    done = 1'b0;
    while (!done) begin
      if (ready === 1'b1) begin
        done = 1'b1;
        drive_cycle(1'b0, '0, '0, '0, '0);
      end else begin
        low_cycles++;
        drive_cycle(1'b1, echo_mem_pkg::sample_t'($urandom()), '0, '0, '0);
        @(negedge clk);
        check_outputs();
      end
    end
    if (low_cycles != echo_mem_pkg::MEM_DEPTH) begin
      $display("CHECK FAILED at %0t: ready low for %0d cycles, expected %0d",
               $time, low_cycles, echo_mem_pkg::MEM_DEPTH);
      error_count++;
    end
  endtask

  initial begin
    int                    n;
    echo_mem_pkg::sample_t sample;
    void'($urandom(SEED));
    reset        = 1'b1;
    sample_in    = '0;
    sample_valid = 1'b0;
    tap_delay    = '0;
    short_shift  = '0;
    long_shift   = '0;
    foreach (hist[i]) begin
      hist[i] = '0;
    end
    read_cases();
    timeout_limit = RESET_CYCLES + echo_mem_pkg::MEM_DEPTH + 2 * total_samples
                    + TIMEOUT_MARGIN;
    repeat (RESET_CYCLES) @(negedge clk);
    if (ready !== 1'b0 || echo_valid !== 1'b0 || echo_out !== '0) begin
      $display("CHECK FAILED at %0t: outputs not idle in reset, ready %0b valid %0b out %0d",
               $time, ready, echo_valid, echo_out);
      error_count++;
    end
    reset = 1'b0;
    watch_clear_phase();
    run_phase = 1'b1;
    for (int i = 0; i < cmd_count; i++) begin
      n = (cmd_kind[i] == "S") ? 1 : cmd_value[i];
      for (int k = 0; k < n; k++) begin
        sample = (cmd_kind[i] == "S") ? echo_mem_pkg::sample_t'(cmd_value[i])
                                      : echo_mem_pkg::sample_t'($urandom());
        run_cycle(1'b1, sample, echo_mem_pkg::addr_t'(cmd_delay[i]),
                  echo_mix_pkg::shift_t'(cmd_short[i]), echo_mix_pkg::shift_t'(cmd_long[i]));
      end
      // Idle gap keeps this line's shifts for its last sample
      // A stray sample sits on the input and must never reach the history
      run_cycle(1'b0, echo_mem_pkg::sample_t'($urandom()), echo_mem_pkg::addr_t'(cmd_delay[i]),
                echo_mix_pkg::shift_t'(cmd_short[i]), echo_mix_pkg::shift_t'(cmd_long[i]));
    end
    repeat (3) run_cycle(1'b0, '0, '0, '0, '0);
    if (expected_q.size() != 0) begin
      $display("Error: %0d expected outputs never appeared", expected_q.size());
      error_count++;
    end
    $display("Checked %0d outputs, %0d errors", checked_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Ends a stuck run once the cycle budget for all cases is spent
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule : echo_unit_tb

// ==== tests/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Free running testbench clock, 100 ns period, starts low
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // Half of the 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule : tb_clock_gen

// ==== src/echo_unit_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Two-tap echo unit, ready stays low for 256 cycles after reset
// Output has no back-pressure, each accept gives echo_valid 2 cycles later
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_unit_top (
  input  logic                  clk,
  input  logic                  reset,
  input  echo_mem_pkg::sample_t sample_in,
  input  logic                  sample_valid,
  input  echo_mem_pkg::addr_t   tap_delay,
  input  echo_mix_pkg::shift_t  short_shift,
  input  echo_mix_pkg::shift_t  long_shift,
  output logic                  ready,
  output echo_mem_pkg::sample_t echo_out,
  output logic                  echo_valid
);

  // Memory requests from the scheduler
  ram_port_if mem_bus ();

  // Echo words and the aligned dry sample, on their way to the mixer
  echo_tap_if tap_bus ();

  // Clear walk, write pointer and tap address generation
  echo_scheduler u_scheduler (
    .clk          (clk),
    .reset        (reset),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .tap_delay    (tap_delay),
    .ready        (ready),
    .mem          (mem_bus.scheduler),
    .tap          (tap_bus.source_sched)
  );

  // Both echo reads happen here in the same cycle
  history_ram u_history (
    .clk (clk),
    .mem (mem_bus.memory),
    .tap (tap_bus.source_mem)
  );

  // Gain, sum and clip stage
  echo_mixer u_mixer (
    .clk         (clk),
    .reset       (reset),
    .short_shift (short_shift),
    .long_shift  (long_shift),
    .tap         (tap_bus.mixer),
    .echo_out    (echo_out),
    .echo_valid  (echo_valid)
  );

endmodule : echo_unit_top

// ==== src/echo_mixer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Dry plus two shifted echoes, saturated to 16 bits and registered
// Shifts round toward minus infinity, no fractional gains
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_mixer (
  input  logic                   clk,
  input  logic                   reset,
  input  echo_mix_pkg::shift_t   short_shift,
  input  echo_mix_pkg::shift_t   long_shift,
  echo_tap_if.mixer              tap,
  output echo_mem_pkg::sample_t  echo_out,
  output logic                   echo_valid
);

  // Each term is sign extended to the accumulator width before scaling
  echo_mix_pkg::acc_t dry_term;
  echo_mix_pkg::acc_t short_term;
  echo_mix_pkg::acc_t long_term;
  echo_mix_pkg::acc_t sum;
  echo_mix_pkg::acc_t clamped;

  always_comb begin
    dry_term   = echo_mix_pkg::acc_t'(tap.dry);
    // Arithmetic shifts keep the sign of negative echoes
    short_term = echo_mix_pkg::acc_t'(tap.q_short) >>> short_shift;
    long_term  = echo_mix_pkg::acc_t'(tap.q_long) >>> long_shift;
    // Two guard bits are enough, three full scale terms cannot overflow
    sum        = dry_term + short_term + long_term;
  end

  // Clip to the 16-bit range
  always_comb begin
    if (sum > echo_mix_pkg::SAT_MAX) begin
      clamped = echo_mix_pkg::SAT_MAX;
    end else if (sum < echo_mix_pkg::SAT_MIN) begin
      clamped = echo_mix_pkg::SAT_MIN;
    end else begin
      clamped = sum;
    end
  end

  // Output register, loaded only on tap cycles and held in between
  always_ff @(posedge clk) begin
    if (reset) begin
      echo_out   <= '0;
      echo_valid <= 1'b0;
    end else begin
      echo_valid <= tap.tap_valid;
      if (tap.tap_valid) begin
        echo_out <= clamped[echo_mem_pkg::DATA_W-1:0];
      end
    end
  end

  // An overflowing sum must come out pinned at the top limit,
  // never wrapped into a negative value
  a_clip_high: assert property (
    @(posedge clk) disable iff (reset)
    (tap.tap_valid && sum > echo_mix_pkg::SAT_MAX)
      |=> echo_out == echo_mem_pkg::sample_t'(echo_mix_pkg::SAT_MAX)
  );

  // And an underflowing sum at the bottom limit
  a_clip_low: assert property (
    @(posedge clk) disable iff (reset)
    (tap.tap_valid && sum < echo_mix_pkg::SAT_MIN)
      |=> echo_out == echo_mem_pkg::sample_t'(echo_mix_pkg::SAT_MIN)
  );

endmodule : echo_mixer

// ==== src/history_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 256 x 16 history, one read/write port and one read port, read-first
// Contents are undefined until the scheduler has cleared them
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module history_ram (
  input  logic           clk,
  ram_port_if.memory     mem,
  echo_tap_if.source_mem tap
);

  // Sample storage, indexed by the scheduler's pointers
  echo_mem_pkg::sample_t ram [echo_mem_pkg::MEM_DEPTH];

  // Port 0 reads the old word before a write replaces it
  // With we0 low this is a plain read, with ce0 low q_long holds
  always_ff @(posedge clk) begin
    if (mem.ce0) begin
      tap.q_long <= ram[mem.addr0];
      if (mem.we0) begin
        ram[mem.addr0] <= mem.d0;
      end
    end
  end

  // Port 1 also sees the old word when port 0 writes the same address,
  // which is what gives a tap delay of 0 its 256-sample echo
  always_ff @(posedge clk) begin
    if (mem.ce1) begin
      tap.q_short <= ram[mem.addr1];
    end
  end

  // Outputs keep their value across any cycle with the enable low
  a_q_long_holds: assert property (
    @(posedge clk) !mem.ce0 |=> $stable(tap.q_long)
  );

  a_q_short_holds: assert property (
    @(posedge clk) !mem.ce1 |=> $stable(tap.q_short)
  );

  // The scheduler must hand over clean requests whenever port 0 is on
  a_port0_known: assert property (
    @(posedge clk) mem.ce0 |-> !$isunknown({mem.we0, mem.addr0, mem.d0})
  );

  // Same for the read-only port
  a_port1_known: assert property (
    @(posedge clk) mem.ce1 |-> !$isunknown(mem.addr1)
  );

endmodule : history_ram

// ==== src/echo_scheduler.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Clears the history memory after reset, then accepts one sample per cycle
// tap_delay is sampled in the accept cycle only
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_scheduler (
  input  logic                  clk,
  input  logic                  reset,
  input  echo_mem_pkg::sample_t sample_in,
  input  logic                  sample_valid,
  input  echo_mem_pkg::addr_t   tap_delay,
  output logic                  ready,
  ram_port_if.scheduler         mem,
  echo_tap_if.source_sched      tap
);

  echo_mix_pkg::sched_state_t state;

  // The write pointer doubles as the clear counter, so it wraps back
  // to address 0 exactly when the clear walk ends
  echo_mem_pkg::addr_t wptr;

  logic clearing;
  logic accept;
  logic wr_en;

  assign clearing = (state == echo_mix_pkg::SCHED_CLEAR);

  // Ready comes straight from the state register
  assign ready = (state == echo_mix_pkg::SCHED_RUN);

  // A strobe only counts once the memory has been wiped
  assign accept = sample_valid && ready;

  // One memory word is written per clear cycle and per accepted sample
  // The clear walk only starts once reset has been released
  assign wr_en = (clearing && !reset) || accept;

  // Port 0 writes zeros during clear and the new sample in run
  assign mem.ce0   = wr_en;
  assign mem.we0   = wr_en;
  assign mem.addr0 = wptr;
  assign mem.d0    = clearing ? '0 : sample_in;

  // Port 1 looks back tap_delay samples, a delay of 0 hits the word
  // being written and read-first returns the oldest sample
  assign mem.ce1   = accept;
  assign mem.addr1 = wptr - tap_delay;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= echo_mix_pkg::SCHED_CLEAR;
      wptr  <= '0;
    end else begin
      if (wr_en) begin
        wptr <= wptr + 1'b1;
      end
      // Leave clear after the last address has been zeroed
      if (clearing && wptr == echo_mem_pkg::LAST_ADDR) begin
        state <= echo_mix_pkg::SCHED_RUN;
      end
    end
  end

  // The valid flag is control state and is cleared by reset
  always_ff @(posedge clk) begin
    if (reset) begin
      tap.tap_valid <= 1'b0;
    end else begin
      tap.tap_valid <= accept;
    end
  end

  // Dry sample lines up with the echo words one cycle later
  always_ff @(posedge clk) begin
    if (accept) begin
      tap.dry <= sample_in;
    end
  end

  // The clear walk hands over with the pointer back at address 0
  a_run_starts_at_zero: assert property (
    @(posedge clk) disable iff (reset) $rose(ready) |-> wptr == '0
  );

  // The mixer sees exactly one tap cycle per accepted sample, one cycle later
  a_tap_follows_accept: assert property (
    @(posedge clk) disable iff (reset) tap.tap_valid == $past(accept)
  );

endmodule : echo_scheduler

// ==== src/echo_tap_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Everything the mixer needs for one output, aligned to the memory read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface echo_tap_if;

  // Echo words straight from the two memory ports
  echo_mem_pkg::sample_t q_long;
  echo_mem_pkg::sample_t q_short;

  // Dry sample and its valid flag, delayed one cycle to match the read
  echo_mem_pkg::sample_t dry;
  logic                  tap_valid;

  modport source_sched (output dry, tap_valid);

  modport source_mem (output q_long, q_short);

  modport mixer (
    input q_long, q_short,
    input dry, tap_valid
  );

endinterface : echo_tap_if

// ==== src/ram_port_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Request side of both memory ports, driven by the scheduler only
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface ram_port_if;

  // Port 0 reads and writes the same address, old data comes out first
  logic                  ce0;
  logic                  we0;
  echo_mem_pkg::addr_t   addr0;
  echo_mem_pkg::sample_t d0;

  // Port 1 only reads
  logic                  ce1;
  echo_mem_pkg::addr_t   addr1;

  // Scheduler side issues all requests
  modport scheduler (
    output ce0, we0, addr0, d0,
    output ce1, addr1
  );

  // Memory side consumes them
  modport memory (
    input ce0, we0, addr0, d0,
    input ce1, addr1
  );

endinterface : ram_port_if

// ==== src/echo_mix_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Mixing types, saturation limits and scheduler states
// ~~~~~~~~~~~~~~~~~~~~
package echo_mix_pkg;

  // Right shift applied to an echo, 0 means full level and 3 means one eighth
  typedef logic [1:0] shift_t;

  // Two guard bits cover the sum of three full scale samples
  localparam int ACC_W = echo_mem_pkg::DATA_W + 2;

  // Signed accumulator for dry sample plus two scaled echoes
  typedef logic signed [ACC_W-1:0] acc_t;

  // Largest and smallest values a 16-bit signed sample can hold
  localparam acc_t SAT_MAX = acc_t'((1 << (echo_mem_pkg::DATA_W - 1)) - 1);
  localparam acc_t SAT_MIN = -SAT_MAX - acc_t'(1);

  // The scheduler first wipes the memory, then runs the echo stream
  typedef enum logic {
    SCHED_CLEAR,
    SCHED_RUN
  } sched_state_t;

endpackage : echo_mix_pkg

// ==== src/echo_mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Geometry of the echo history memory and the sample and address types
// Depth must stay a power of two so the pointers wrap by themselves
// ~~~~~~~~~~~~~~~~~~~~
package echo_mem_pkg;

  // Width of one audio sample in bits
  localparam int DATA_W = 16;

  // Address width of the history memory
  localparam int ADDR_W = 8;

  // Number of words in the history memory
  // This sets both the length of the clear phase and the long echo delay
  localparam int MEM_DEPTH = 1 << ADDR_W;

  // A signed two's complement audio sample
  typedef logic signed [DATA_W-1:0] sample_t;

  // A memory address, also used as the short tap delay in samples
  typedef logic [ADDR_W-1:0] addr_t;

  // Last address of the memory, where the clear walk ends
  localparam addr_t LAST_ADDR = addr_t'(MEM_DEPTH - 1);

endpackage : echo_mem_pkg
